// File: flist.f
logic/axi3_conv_pkg.sv
logic/ar_burst_splitter.sv
logic/split_cmd_fifo.sv
logic/r_burst_merger.sv
logic/axi3_read_conv.sv
test/axi3_read_conv_asserts.sv
test/tb_axi3_read_conv.sv

// File: Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -j 0
TOP       ?= tb_axi3_read_conv
FLIST     ?= flist.f
PASS_MSG  := All tests passed!
SIM_BIN   := obj_dir/V$(TOP)

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only --timing -f $(FLIST) --top-module $(TOP)

$(SIM_BIN): $(FLIST) $(shell cat $(FLIST))
	$(VERILATOR) $(FLAGS) -f $(FLIST) --top-module $(TOP)

# pass only when the run prints the pass message.
sim: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf obj_dir

// File: test/tb_axi3_read_conv.sv
`timescale 1ns/1ps

module tb_axi3_read_conv
  import axi3_conv_pkg::*;
();

  localparam int         beat_bytes     = 4;   // every test reads with size 2.
  localparam logic [2:0] beat_size      = 3'd2;
  localparam int         total_beats    = 153;
  localparam int         timeout_cycles = 200 * total_beats;

  logic                  aclk = 1'b0;
  logic                  rst_n;
  logic [id_w-1:0]       s_arid, s_rid, m_arid;
  logic [id_w-1:0]       m_rid = '0;
  logic [addr_w-1:0]     s_araddr, m_araddr;
  logic [axi4_len_w-1:0] s_arlen;
  logic [axi3_len_w-1:0] m_arlen;
  logic [2:0]            s_arsize, m_arsize;
  logic [1:0]            s_arburst, m_arburst, s_rresp;
  logic [1:0]            m_rresp = resp_okay;
  logic [data_w-1:0]     s_rdata;
  logic [data_w-1:0]     m_rdata = '0;
  logic                  s_arvalid, s_arready, m_arvalid, s_rvalid, s_rlast, m_rready;
  logic                  m_arready = 1'b0;
  logic                  m_rvalid = 1'b0;
  logic                  m_rlast = 1'b0;
  logic                  s_rready = 1'b0;

  integer                seed = 20550;
  logic [31:0]           rnd;
  logic                  random_rready;
  logic [1:0]            slave_resp;
  logic                  r_taken = 1'b0;
  int                    beat_idx = 0;   // beat within the oldest piece.
  int                    errors;
  int                    ar_base;
  int                    rx_base;
  logic [addr_w-1:0]     pend_addr[$];
  logic [axi3_len_w-1:0] pend_len[$];
  logic [id_w-1:0]       pend_id[$];
  logic [addr_w-1:0]     ar_addr_log[$];
  logic [axi3_len_w-1:0] ar_len_log[$];
  logic [2:0]            ar_size_log[$];
  logic [1:0]            ar_burst_log[$];
  logic [id_w-1:0]       rx_id[$];
  logic [data_w-1:0]     rx_data[$];
  logic [1:0]            rx_resp[$];
  logic                  rx_last[$];

  always #5 aclk = ~aclk;

  axi3_read_conv i_dut (.*);

  bind axi3_read_conv axi3_read_conv_asserts i_asserts (.*);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // axi3 slave model and axi4 beat capture
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always @(posedge aclk) begin
    r_taken = rst_n && m_rvalid && m_rready;
    if (r_taken) begin
      beat_idx = m_rlast ? 0 : beat_idx + 1;
      if (m_rlast) begin
        void'(pend_addr.pop_front());
        void'(pend_len.pop_front());
        void'(pend_id.pop_front());
      end
    end
    if (rst_n && m_arvalid && m_arready) begin
      pend_addr.push_back(m_araddr);
      pend_len.push_back(m_arlen);
      pend_id.push_back(m_arid);
      ar_addr_log.push_back(m_araddr);
      ar_len_log.push_back(m_arlen);
      ar_size_log.push_back(m_arsize);
      ar_burst_log.push_back(m_arburst);
    end
    if (rst_n && s_rvalid && s_rready) begin
      rx_id.push_back(s_rid);
      rx_data.push_back(s_rdata);
      rx_resp.push_back(s_rresp);
      rx_last.push_back(s_rlast);
    end
  end

  always @(negedge aclk) begin
    rnd       = $random(seed);
    m_arready = rnd[1:0] != 2'b00;   // stalls one cycle in four.
    s_rready  = !random_rready || rnd[4];
    if (!m_rvalid || r_taken) begin
      m_rvalid = (pend_addr.size() > 0) && (rnd[3:2] != 2'b00);
      if (m_rvalid) begin
        m_rid   = pend_id[0];
        m_rdata = pend_addr[0] + data_w'(beat_bytes * beat_idx);
        m_rresp = slave_resp;
        m_rlast = beat_idx == int'(pend_len[0]);
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // driver and checking tasks
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  task automatic report_mismatch(input string test, input string what,
                                 input logic [31:0] expected, input logic [31:0] actual);
    errors++;
    $display("[FAIL] %s: %s expected 0x%0h actual 0x%0h", test, what, expected, actual);
  endtask

  task automatic send_read(input logic [id_w-1:0] id, input logic [addr_w-1:0] addr,
                           input logic [axi4_len_w-1:0] len, input logic [1:0] burst);
    @(negedge aclk);
    s_arid    = id;
    s_araddr  = addr;
    s_arlen   = len;
    s_arburst = burst;
    s_arvalid = 1'b1;
    @(posedge aclk);
    while (!s_arready) @(posedge aclk);
    @(negedge aclk);
    s_arvalid = 1'b0;
  endtask

  task automatic wait_done(input string test, input int beats, input int pieces);
    while (rx_data.size() - rx_base < beats) @(negedge aclk);
    repeat (20) @(negedge aclk);   // room for stray extra beats.
    if (rx_data.size() - rx_base != beats) begin
      report_mismatch(test, "beat count", beats, rx_data.size() - rx_base);
    end
    if (ar_addr_log.size() - ar_base != pieces) begin
      report_mismatch(test, "AXI3 request count", pieces, ar_addr_log.size() - ar_base);
    end
  endtask

  function automatic logic [data_w-1:0] expected_data(input logic [addr_w-1:0] base,
                                                      input logic [1:0] burst, input int k);
    logic [addr_w-1:0] piece_addr;
    piece_addr = base;
    if (burst == burst_incr) begin
      piece_addr = base + addr_w'((k / axi3_max_beats) * axi3_max_beats * beat_bytes);
    end
    return piece_addr + data_w'((k % axi3_max_beats) * beat_bytes);
  endfunction

  task automatic check_pieces(input string test, input int first,
                              input logic [addr_w-1:0] base, input logic [1:0] burst,
                              input int beats);
    int p;
    int left;
    logic [addr_w-1:0]     exp_addr;
    logic [axi3_len_w-1:0] exp_len;
    left = beats;
    for (p = ar_base + first; left > 0; p++) begin
      if (p >= ar_addr_log.size()) begin
        errors++;
        $display("%s: AXI3 request %0d was never issued", test, p - ar_base);
        break;
      end
      exp_addr = base;
      if (burst == burst_incr) begin
        exp_addr = base + addr_w'((p - ar_base - first) * axi3_max_beats * beat_bytes);
      end
      exp_len = axi3_len_w'(((left > axi3_max_beats) ? axi3_max_beats : left) - 1);
      if (ar_addr_log[p] !== exp_addr) report_mismatch(test, "m_araddr", exp_addr, ar_addr_log[p]);
      if (ar_len_log[p] !== exp_len) begin
        report_mismatch(test, "m_arlen", 32'(exp_len), 32'(ar_len_log[p]));
      end
      if (ar_size_log[p] !== beat_size) begin
        report_mismatch(test, "m_arsize", 32'(beat_size), 32'(ar_size_log[p]));
      end
      if (ar_burst_log[p] !== burst) begin
        report_mismatch(test, "m_arburst", 32'(burst), 32'(ar_burst_log[p]));
      end
      left -= axi3_max_beats;
    end
  endtask

  task automatic check_beats(input string test, input int first, input int n,
                             input logic [addr_w-1:0] base, input logic [1:0] burst,
                             input logic [id_w-1:0] id, input logic [1:0] resp);
    int k;
    int i;
    logic [data_w-1:0] exp_data;
    for (k = 0; k < n && rx_base + first + k < rx_data.size(); k++) begin
      i        = rx_base + first + k;
      exp_data = expected_data(base, burst, k);
      if (rx_data[i] !== exp_data) begin
        report_mismatch(test, $sformatf("rdata of beat %0d", k), exp_data, rx_data[i]);
      end
      if (rx_last[i] !== (k == n - 1)) begin
        report_mismatch(test, $sformatf("rlast of beat %0d", k), 32'(k == n - 1),
                        32'(rx_last[i]));
      end
      if (rx_id[i] !== id) report_mismatch(test, "rid", 32'(id), 32'(rx_id[i]));
      if (rx_resp[i] !== resp) report_mismatch(test, "rresp", 32'(resp), 32'(rx_resp[i]));
    end
  endtask

  task automatic single_burst(input string test, input logic [id_w-1:0] id,
                              input logic [addr_w-1:0] addr, input int beats,
                              input logic [1:0] burst, input logic [1:0] resp);
    ar_base = ar_addr_log.size();
    rx_base = rx_data.size();
    send_read(id, addr, axi4_len_w'(beats - 1), burst);
    wait_done(test, beats, (beats + axi3_max_beats - 1) / axi3_max_beats);
    check_pieces(test, 0, addr, burst, beats);
    check_beats(test, 0, beats, addr, burst, id, resp);
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // directed tests
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  task automatic reset_state();
    if (s_arready !== 1'b1) report_mismatch("reset", "s_arready", 1, 32'(s_arready));
    if (m_arvalid !== 1'b0) report_mismatch("reset", "m_arvalid", 0, 32'(m_arvalid));
    if (s_rvalid !== 1'b0) report_mismatch("reset", "s_rvalid", 0, 32'(s_rvalid));
  endtask

  task automatic short_incr_burst();
    single_burst("short_incr", 4'h1, 32'h0000_1000, 8, burst_incr, resp_okay);
  endtask

  task automatic long_incr_burst();
    single_burst("long_incr", 4'h2, 32'h0000_2000, 40, burst_incr, resp_okay);
  endtask

  task automatic fixed_burst();
    single_burst("fixed_burst", 4'h3, 32'h0000_3000, 21, burst_fixed, resp_okay);
  endtask

  task automatic rready_backpressure();
    random_rready = 1'b1;
    slave_resp    = resp_slverr;
    single_burst("backpressure", 4'h5, 32'h0000_4000, 64, burst_incr, resp_slverr);
    random_rready = 1'b0;
    slave_resp    = resp_okay;
  endtask

  task automatic back_to_back_reads();
    ar_base = ar_addr_log.size();
    rx_base = rx_data.size();
    send_read(4'h6, 32'h0000_5000, 8'd16, burst_incr);
    send_read(4'h9, 32'h0000_6000, 8'd2, burst_incr);
    wait_done("back_to_back", 20, 3);
    check_pieces("back_to_back", 0, 32'h0000_5000, burst_incr, 17);
    check_pieces("back_to_back", 2, 32'h0000_6000, burst_incr, 3);
    check_beats("back_to_back", 0, 17, 32'h0000_5000, burst_incr, 4'h6, resp_okay);
    check_beats("back_to_back", 17, 3, 32'h0000_6000, burst_incr, 4'h9, resp_okay);
  endtask

  initial begin
    errors        = 0;
    random_rready = 1'b0;
    slave_resp    = resp_okay;
    rst_n         = 1'b0;
    s_arid        = '0;
    s_araddr      = '0;
    s_arlen       = '0;
    s_arsize      = beat_size;
    s_arburst     = burst_incr;
    s_arvalid     = 1'b0;
    repeat (10) @(negedge aclk);
    rst_n = 1'b1;
    reset_state();
    short_incr_burst();
    long_incr_burst();
    fixed_burst();
    rready_backpressure();
    back_to_back_reads();
    $display("tb_axi3_read_conv finished with %0d errors", errors);
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

  initial begin : watchdog
    repeat (timeout_cycles) @(posedge aclk);
    $display("timeout: the tests did not finish within %0d cycles", timeout_cycles);
    $display("Test failures found");
    $finish;
  end

endmodule

// File: test/axi3_read_conv_asserts.sv
`timescale 1ns/1ps

module axi3_read_conv_asserts
  import axi3_conv_pkg::*;
(
  input logic                  aclk,
  input logic                  rst_n,
  input logic [id_w-1:0]       s_arid, m_arid, s_rid, m_rid,
  input logic [addr_w-1:0]     s_araddr, m_araddr,
  input logic [data_w-1:0]     s_rdata, m_rdata,
  input logic [axi4_len_w-1:0] s_arlen,
  input logic [axi3_len_w-1:0] m_arlen,
  input logic [2:0]            s_arsize, m_arsize,
  input logic [1:0]            s_arburst, m_arburst, s_rresp, m_rresp,
  input logic                  s_arvalid, s_arready, m_arvalid, m_arready,
  input logic                  s_rvalid, s_rready, s_rlast, m_rvalid, m_rready, m_rlast,
  input logic                  cmd_push_ready, cmd_valid
);

  // a stalled valid keeps itself and its payload.
  s_ar_hold: assert property (@(posedge aclk) disable iff (!rst_n)
    s_arvalid && !s_arready |=> s_arvalid && $stable({s_arid, s_araddr, s_arlen, s_arsize,
                                                      s_arburst}))
    else $error("s_ar request dropped or changed before its transfer");

  m_ar_hold: assert property (@(posedge aclk) disable iff (!rst_n)
    m_arvalid && !m_arready |=> m_arvalid && $stable({m_arid, m_araddr, m_arlen, m_arsize,
                                                      m_arburst}))
    else $error("m_ar request dropped or changed before its transfer");

  s_r_hold: assert property (@(posedge aclk) disable iff (!rst_n)
    s_rvalid && !s_rready |=> s_rvalid && $stable({s_rid, s_rdata, s_rresp, s_rlast}))
    else $error("s_r beat dropped or changed before its transfer");

  m_r_hold: assert property (@(posedge aclk) disable iff (!rst_n)
    m_rvalid && !m_rready |=> m_rvalid && $stable({m_rid, m_rdata, m_rresp, m_rlast}))
    else $error("m_r beat dropped or changed before its transfer");

  ar_needs_room: assert property (@(posedge aclk) disable iff (!rst_n)
    !(m_arvalid && !cmd_push_ready))
    else $error("m_arvalid high while the command FIFO is full");

  r_needs_cmd: assert property (@(posedge aclk) disable iff (!rst_n)
    s_rvalid |-> cmd_valid)
    else $error("s_rvalid high with no pending command");

endmodule

// File: logic/axi3_read_conv.sv
`timescale 1ns/1ps

module axi3_read_conv
  import axi3_conv_pkg::*;
(
  input  logic                  aclk,
  input  logic                  rst_n,
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // axi4 slave port
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  input  logic [id_w-1:0]       s_arid,
  input  logic [addr_w-1:0]     s_araddr,
  input  logic [axi4_len_w-1:0] s_arlen,
  input  logic [2:0]            s_arsize,
  input  logic [1:0]            s_arburst,
  input  logic                  s_arvalid,
  output logic                  s_arready,
  output logic [id_w-1:0]       s_rid,
  output logic [data_w-1:0]     s_rdata,
  output logic [1:0]            s_rresp,
  output logic                  s_rlast,
  output logic                  s_rvalid,
  input  logic                  s_rready,
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // axi3 master port
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  output logic [id_w-1:0]       m_arid,
  output logic [addr_w-1:0]     m_araddr,
  output logic [axi3_len_w-1:0] m_arlen,
  output logic [2:0]            m_arsize,
  output logic [1:0]            m_arburst,
  output logic                  m_arvalid,
  input  logic                  m_arready,
  input  logic [id_w-1:0]       m_rid,
  input  logic [data_w-1:0]     m_rdata,
  input  logic [1:0]            m_rresp,
  input  logic                  m_rlast,
  input  logic                  m_rvalid,
  output logic                  m_rready
);

  logic cmd_push_valid;
  logic cmd_push_split;
  logic cmd_push_ready;
  logic cmd_valid;
  logic cmd_split;
  logic cmd_ready;

  ar_burst_splitter i_splitter (
    .aclk           (aclk),
    .rst_n          (rst_n),
    .s_arid         (s_arid),
    .s_araddr       (s_araddr),
    .s_arlen        (s_arlen),
    .s_arsize       (s_arsize),
    .s_arburst      (s_arburst),
    .s_arvalid      (s_arvalid),
    .s_arready      (s_arready),
    .m_arid         (m_arid),
    .m_araddr       (m_araddr),
    .m_arlen        (m_arlen),
    .m_arsize       (m_arsize),
    .m_arburst      (m_arburst),
    .m_arvalid      (m_arvalid),
    .m_arready      (m_arready),
    .cmd_push_valid (cmd_push_valid),
    .cmd_push_split (cmd_push_split),
    .cmd_push_ready (cmd_push_ready)
  );

  split_cmd_fifo i_cmd_fifo (
    .aclk       (aclk),
    .rst_n      (rst_n),
    .push_valid (cmd_push_valid),
    .push_data  (cmd_push_split),
    .push_ready (cmd_push_ready),
    .pop_valid  (cmd_valid),
    .pop_data   (cmd_split),
    .pop_ready  (cmd_ready)
  );

  r_burst_merger i_merger (
    .cmd_valid (cmd_valid),
    .cmd_split (cmd_split),
    .cmd_ready (cmd_ready),
    .m_rid     (m_rid),
    .m_rdata   (m_rdata),
    .m_rresp   (m_rresp),
    .m_rlast   (m_rlast),
    .m_rvalid  (m_rvalid),
    .m_rready  (m_rready),
    .s_rid     (s_rid),
    .s_rdata   (s_rdata),
    .s_rresp   (s_rresp),
    .s_rlast   (s_rlast),
    .s_rvalid  (s_rvalid),
    .s_rready  (s_rready)
  );

endmodule

// File: logic/r_burst_merger.sv
`timescale 1ns/1ps

module r_burst_merger
  import axi3_conv_pkg::*;
(
  // command queue pop
  input  logic              cmd_valid,
  input  logic              cmd_split,
  output logic              cmd_ready,
  // axi3 read data in
  input  logic [id_w-1:0]   m_rid,
  input  logic [data_w-1:0] m_rdata,
  input  logic [1:0]        m_rresp,
  input  logic              m_rlast,
  input  logic              m_rvalid,
  output logic              m_rready,
  // axi4 read data out
  output logic [id_w-1:0]   s_rid,
  output logic [data_w-1:0] s_rdata,
  output logic [1:0]        s_rresp,
  output logic              s_rlast,
  output logic              s_rvalid,
  input  logic              s_rready
);

  logic stalled;
  logic beat_xfer;

  // beats only move while a piece is known.
  assign s_rvalid  = m_rvalid & cmd_valid;
  assign stalled   = s_rvalid & ~s_rready;
  assign m_rready  = cmd_valid & ~stalled;
  assign beat_xfer = s_rvalid & s_rready;

  // one command per finished piece.
  assign cmd_ready = beat_xfer & m_rlast;

  assign s_rid   = m_rid;
  assign s_rdata = m_rdata;
  assign s_rresp = m_rresp;
  assign s_rlast = m_rlast & ~cmd_split;  // hide end of non-final piece.

endmodule

// File: logic/split_cmd_fifo.sv
`timescale 1ns/1ps

module split_cmd_fifo
  import axi3_conv_pkg::*;
(
  input  logic aclk,
  input  logic rst_n,
  input  logic push_valid,
  input  logic push_data,
  output logic push_ready,
  output logic pop_valid,
  output logic pop_data,
  input  logic pop_ready
);

  localparam int ptr_w = (cmd_depth > 1) ? $clog2(cmd_depth) : 1;
  localparam int cnt_w = $clog2(cmd_depth + 1);

  logic [cmd_depth-1:0] mem;
  logic [ptr_w-1:0]     wr_ptr;
  logic [ptr_w-1:0]     rd_ptr;
  logic [cnt_w-1:0]     count;
  logic                 do_push;
  logic                 do_pop;

  assign push_ready = count != cnt_w'(cmd_depth);
  assign pop_valid  = count != '0;
  assign pop_data   = mem[rd_ptr];

  assign do_push = push_valid & push_ready;
  assign do_pop  = pop_valid & pop_ready;

  always_ff @(posedge aclk) begin
    if (do_push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  always_ff @(posedge aclk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= (wr_ptr == ptr_w'(cmd_depth - 1)) ? '0 : wr_ptr + ptr_w'(1);
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == ptr_w'(cmd_depth - 1)) ? '0 : rd_ptr + ptr_w'(1);
      end
      case ({do_push, do_pop})
        2'b10:   count <= count + cnt_w'(1);
        2'b01:   count <= count - cnt_w'(1);
        default: count <= count;   // both or neither.
      endcase
    end
  end

endmodule

// File: logic/ar_burst_splitter.sv
`timescale 1ns/1ps

module ar_burst_splitter
  import axi3_conv_pkg::*;
(
  input  logic                  aclk,
  input  logic                  rst_n,
  // axi4 request in
  input  logic [id_w-1:0]       s_arid,
  input  logic [addr_w-1:0]     s_araddr,
  input  logic [axi4_len_w-1:0] s_arlen,
  input  logic [2:0]            s_arsize,
  input  logic [1:0]            s_arburst,
  input  logic                  s_arvalid,
  output logic                  s_arready,
  // axi3 pieces out
  output logic [id_w-1:0]       m_arid,
  output logic [addr_w-1:0]     m_araddr,
  output logic [axi3_len_w-1:0] m_arlen,
  output logic [2:0]            m_arsize,
  output logic [1:0]            m_arburst,
  output logic                  m_arvalid,
  input  logic                  m_arready,
  // command queue push
  output logic                  cmd_push_valid,
  output logic                  cmd_push_split,
  input  logic                  cmd_push_ready
);

  localparam int rem_w = axi4_len_w + 1;

  logic                  busy;
  logic [id_w-1:0]       id_q;
  logic [addr_w-1:0]     addr_q;
  logic [2:0]            size_q;
  logic [1:0]            burst_q;
  logic [rem_w-1:0]      remain_q;   // beats not yet issued.

  logic                  more;
  logic [rem_w-1:0]      piece_beats;
  logic [addr_w-1:0]     step;
  logic                  s_xfer;
  logic                  m_xfer;

  assign more        = remain_q > rem_w'(axi3_max_beats);
  assign piece_beats = more ? rem_w'(axi3_max_beats) : remain_q;
  assign step        = addr_w'(axi3_max_beats) << size_q;

  assign s_arready = ~busy;
  assign s_xfer    = s_arvalid & s_arready;

  // no piece without room for its command.
  assign m_arvalid = busy & cmd_push_ready;
  assign m_xfer    = m_arvalid & m_arready;

  assign m_arid    = id_q;
  assign m_araddr  = addr_q;
  assign m_arlen   = axi3_len_w'(piece_beats - rem_w'(1));
  assign m_arsize  = size_q;
  assign m_arburst = burst_q;

  assign cmd_push_valid = m_xfer;
  assign cmd_push_split = more;

  always_ff @(posedge aclk) begin
    if (!rst_n) begin
      busy <= 1'b0;
    end else if (s_xfer) begin
      busy <= 1'b1;
    end else if (m_xfer && !more) begin
      busy <= 1'b0;  // final piece gone.
    end
  end

  always_ff @(posedge aclk) begin
    if (s_xfer) begin
      id_q     <= s_arid;
      addr_q   <= s_araddr;
      size_q   <= s_arsize;
      burst_q  <= s_arburst;
      remain_q <= rem_w'(s_arlen) + rem_w'(1);
    end else if (m_xfer) begin
      remain_q <= remain_q - piece_beats;
      case (burst_q)
        burst_incr: addr_q <= addr_q + step;
        burst_fixed,
        burst_wrap:  addr_q <= addr_q;   // single piece for wrap.
        default:     addr_q <= addr_q;
      endcase
    end
  end

endmodule

// File: logic/axi3_conv_pkg.sv
package axi3_conv_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // bus widths
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  localparam int id_w       = 4;
  localparam int addr_w     = 32;
  localparam int data_w     = 32;
  localparam int axi4_len_w = 8;   // up to 256 beats.
  localparam int axi3_len_w = 4;   // up to 16 beats.

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // splitting limits
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  localparam int axi3_max_beats = 16;

  // pieces in flight between request and response side.
  localparam int cmd_depth = 4;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // burst type codes
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  localparam logic [1:0] burst_fixed = 2'b00;
  localparam logic [1:0] burst_incr  = 2'b01;
  localparam logic [1:0] burst_wrap  = 2'b10;  // at most 16 beats, never split.

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // response codes
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  localparam logic [1:0] resp_okay   = 2'b00;
  localparam logic [1:0] resp_exokay = 2'b01;
  localparam logic [1:0] resp_slverr = 2'b10;
  localparam logic [1:0] resp_decerr = 2'b11;

endpackage
